// ==== source/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  localparam int XLEN = 32;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_SLE  = 4'd10,
    ALU_SLEU = 4'd11
  } alu_op_e;

  // zero system funct3 selects ecall / ebreak / mret
  localparam logic [2:0] F3_PRIV   = 3'b000;
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
  localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
  localparam logic [11:0] FUNCT12_MRET   = 12'h302;

  localparam int unsigned CAUSE_ECALL_M = 11;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  // rs1 slot holds zimm and imm12 holds csr / funct12
  typedef struct packed {
    logic [11:0] csr_funct12;
    logic [4:0]  zimm;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } sys_t;

  typedef union packed {
    itype_t itype;
    sys_t   sys;
  } inst_u;

endpackage

`default_nettype wire

// ==== source/exu_issue_if.sv ====
`default_nettype none

interface exu_issue_if
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) ();

  logic            valid;
  logic            ready;
  inst_u           inst;
  logic [XLEN-1:0] pc;
  // operands as picked by decode
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] imm;
  alu_op_e         alu_op;

  modport src (
    output valid, inst, pc, src1, src2, base, imm, alu_op,
    input  ready
  );

  modport dst (
    input  valid, inst, pc, src1, src2, base, imm, alu_op,
    output ready
  );

endinterface

`default_nettype wire

// ==== source/exu_csr_if.sv ====
`default_nettype none

interface exu_csr_if
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) ();

  logic            commit;
  inst_u           inst;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] operand;
  logic [XLEN-1:0] rdata;

  modport core (
    output commit, inst, pc, operand,
    input  rdata
  );

  modport csr (
    input  commit, inst, pc, operand,
    output rdata
  );

endinterface

`default_nettype wire

// ==== source/exu_alu.sv ====
`default_nettype none

module exu_alu
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  wire logic [XLEN-1:0] src1_i,
  input  wire logic [XLEN-1:0] src2_i,
  input  wire alu_op_e         op_i,
  output logic      [XLEN-1:0] result_o
);

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_s;
  logic           lt_u;
  logic           eq;

  assign shamt = src2_i[SHW-1:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  always_comb begin
    result_o = '0;
    case (op_i)
      ALU_ADD:  result_o = src1_i + src2_i;
      ALU_SUB:  result_o = src1_i - src2_i;
      ALU_SLL:  result_o = src1_i << shamt;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  result_o = src1_i ^ src2_i;
      ALU_SRL:  result_o = src1_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(src1_i) >>> shamt);
      ALU_OR:   result_o = src1_i | src2_i;
      ALU_AND:  result_o = src1_i & src2_i;
      // used by bge / bgeu with swapped operands
      ALU_SLE:  result_o = {{(XLEN-1){1'b0}}, lt_s | eq};
      ALU_SLEU: result_o = {{(XLEN-1){1'b0}}, lt_u | eq};
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/exu_csr.sv ====
`default_nettype none

module exu_csr
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  wire logic            clk,
  input  wire logic            rst,
  exu_csr_if.csr               csr_if,
  output logic      [XLEN-1:0] trap_vec_o,
  output logic      [XLEN-1:0] epc_o
);

  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  logic [11:0]     addr;
  logic [2:0]      funct3;
  logic            is_sys;
  logic            csr_op;
  logic            is_ecall;
  logic            is_mret;
  logic            addr_known;
  logic [XLEN-1:0] wdata;

  assign addr       = csr_if.inst.sys.csr_funct12;
  assign funct3     = csr_if.inst.sys.funct3;
  assign is_sys     = csr_if.inst.sys.opcode == OPC_SYSTEM;
  assign csr_op     = is_sys && funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC,
                                               F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};
  assign is_ecall   = is_sys && funct3 == F3_PRIV && addr == FUNCT12_ECALL;
  assign is_mret    = is_sys && funct3 == F3_PRIV && addr == FUNCT12_MRET;
  assign addr_known = addr inside {CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};

  always_comb begin
    case (addr)
      CSR_MSTATUS: csr_if.rdata = mstatus;
      CSR_MTVEC:   csr_if.rdata = mtvec;
      CSR_MEPC:    csr_if.rdata = mepc;
      CSR_MCAUSE:  csr_if.rdata = mcause;
      default:     csr_if.rdata = '0;
    endcase
  end

  // funct3[1:0] picks write / set / clear for both operand forms
  always_comb begin
    case (funct3[1:0])
      2'b01:   wdata = csr_if.operand;
      2'b10:   wdata = csr_if.rdata | csr_if.operand;
      2'b11:   wdata = csr_if.rdata & ~csr_if.operand;
      default: wdata = csr_if.rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (csr_if.commit) begin
      if (csr_op) begin
        case (addr)
          CSR_MSTATUS: mstatus <= wdata;
          CSR_MTVEC:   mtvec   <= wdata;
          CSR_MEPC:    mepc    <= wdata;
          CSR_MCAUSE:  mcause  <= wdata;
          default:     ;
        endcase
      end else if (is_ecall) begin
        mepc   <= csr_if.pc;
        mcause <= XLEN'(CAUSE_ECALL_M);
      end else if (is_mret) begin
        mstatus[MIE_BIT]  <= mstatus[MPIE_BIT];
        mstatus[MPIE_BIT] <= 1'b1;
      end
    end
  end

  assign trap_vec_o = mtvec;
  assign epc_o      = mepc;

  // decode upstream must never hand us a csr we do not implement
  a_known_csr: assert property (@(posedge clk) disable iff (rst)
    csr_if.commit && csr_op |-> addr_known);

endmodule

`default_nettype wire

// ==== source/exu_redirect.sv ====
`default_nettype none

module exu_redirect
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  wire inst_u           inst_i,
  input  wire logic [XLEN-1:0] alu_result_i,
  input  wire logic [XLEN-1:0] target_i,
  input  wire logic [XLEN-1:0] trap_vec_i,
  input  wire logic [XLEN-1:0] epc_i,
  input  wire alu_op_e         alu_op_i,
  output logic                 taken_o,
  output logic      [XLEN-1:0] npc_o
);

  logic nonzero;

  assign nonzero = |alu_result_i;

  always_comb begin
    taken_o = 1'b0;
    npc_o   = target_i;
    case (inst_i.sys.opcode)
      OPC_JAL, OPC_JALR: taken_o = 1'b1;
      OPC_BRANCH: begin
        case (alu_op_i)
          ALU_SUB:  taken_o = !nonzero;
          ALU_XOR,
          ALU_SLT,
          ALU_SLTU,
          ALU_SLE,
          ALU_SLEU: taken_o = nonzero;
          default:  taken_o = 1'b0;
        endcase
      end
      OPC_SYSTEM: begin
        if (inst_i.sys.funct3 == F3_PRIV) begin
          if (inst_i.sys.csr_funct12 == FUNCT12_ECALL) begin
            taken_o = 1'b1;
            npc_o   = trap_vec_i;
          end else if (inst_i.sys.csr_funct12 == FUNCT12_MRET) begin
            taken_o = 1'b1;
            npc_o   = epc_i;
          end
        end
      end
      default: taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/exu_core.sv ====
`default_nettype none

module exu_core
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  wire logic            clk,
  input  wire logic            rst,
  exu_issue_if.dst             issue,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic      [XLEN-1:0] mem_addr_o,
  output logic      [XLEN-1:0] mem_wdata_o,
  input  wire logic [XLEN-1:0] mem_rdata_i,
  input  wire logic            mem_rvalid_i,
  input  wire logic            mem_wready_i,
  output logic                 ex_valid_o,
  input  wire logic            ex_ready_i,
  output logic      [4:0]      rd_o,
  output logic      [XLEN-1:0] rd_wdata_o,
  output logic                 redirect_o,
  output logic      [XLEN-1:0] npc_o,
  output logic                 ebreak_o
);

  exu_csr_if #(.XLEN(XLEN)) csr_bus ();

  // instruction register
  inst_u           inst_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] src1_q;
  logic [XLEN-1:0] src2_q;
  logic [XLEN-1:0] base_q;
  logic [XLEN-1:0] imm_q;
  alu_op_e         alu_op_q;
  logic [XLEN-1:0] load_data_q;

  logic            valid_q;
  logic            req_q;

  logic            accept;
  logic            issue_mem;
  logic            is_load;
  logic            is_store;
  logic            is_sys;
  logic            has_rd;
  logic            mem_done;
  logic            taken;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] trap_vec;
  logic [XLEN-1:0] epc;

  assign issue_mem = issue.inst.itype.opcode inside {OPC_LOAD, OPC_STORE};
  assign is_load   = inst_q.itype.opcode == OPC_LOAD;
  assign is_store  = inst_q.itype.opcode == OPC_STORE;
  assign is_sys    = inst_q.itype.opcode == OPC_SYSTEM;
  assign has_rd    = !(is_store || inst_q.itype.opcode == OPC_BRANCH);
  assign mem_done  = req_q && (is_load ? mem_rvalid_i : mem_wready_i);

  // a new instruction may enter while the old one leaves
  assign issue.ready = !req_q && (!valid_q || ex_ready_i);
  assign accept      = issue.valid && issue.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      req_q   <= 1'b0;
    end else begin
      if (valid_q && ex_ready_i) valid_q <= 1'b0;
      if (mem_done) begin
        req_q   <= 1'b0;
        valid_q <= 1'b1;
      end
      if (accept) begin
        if (issue_mem) req_q <= 1'b1;
        else valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q   <= issue.inst;
      pc_q     <= issue.pc;
      src1_q   <= issue.src1;
      src2_q   <= issue.src2;
      base_q   <= issue.base;
      imm_q    <= issue.imm;
      alu_op_q <= issue.alu_op;
    end
    if (mem_done && is_load) load_data_q <= mem_rdata_i;
  end

  assign target = base_q + imm_q;

  exu_alu #(.XLEN(XLEN)) i_alu (
    .src1_i   (src1_q),
    .src2_i   (src2_q),
    .op_i     (alu_op_q),
    .result_o (alu_result)
  );

  // csr state moves only on the output handshake
  assign csr_bus.commit  = valid_q && ex_ready_i && is_sys;
  assign csr_bus.inst    = inst_q;
  assign csr_bus.pc      = pc_q;
  assign csr_bus.operand = inst_q.sys.funct3[2] ? {{(XLEN-5){1'b0}}, inst_q.sys.zimm} : src1_q;

  exu_csr #(.XLEN(XLEN)) i_csr (
    .clk        (clk),
    .rst        (rst),
    .csr_if     (csr_bus),
    .trap_vec_o (trap_vec),
    .epc_o      (epc)
  );

  exu_redirect #(.XLEN(XLEN)) i_redirect (
    .inst_i       (inst_q),
    .alu_result_i (alu_result),
    .target_i     (target),
    .trap_vec_i   (trap_vec),
    .epc_i        (epc),
    .alu_op_i     (alu_op_q),
    .taken_o      (taken),
    .npc_o        (npc_o)
  );

  assign mem_req_o   = req_q;
  assign mem_we_o    = is_store;
  assign mem_addr_o  = target;
  assign mem_wdata_o = src2_q;

  assign ex_valid_o = valid_q;
  assign rd_o       = has_rd ? inst_q.itype.rd : 5'd0;
  assign redirect_o = valid_q && taken;
  assign ebreak_o   = valid_q && is_sys && inst_q.sys.funct3 == F3_PRIV &&
                      inst_q.sys.csr_funct12 == FUNCT12_EBREAK;

  always_comb begin
    if (rd_o == 5'd0) rd_wdata_o = '0;
    else if (is_load) rd_wdata_o = load_data_q;
    else if (is_sys) rd_wdata_o = csr_bus.rdata;
    else rd_wdata_o = alu_result;
  end

  a_hold_result: assert property (@(posedge clk) disable iff (rst)
    ex_valid_o && !ex_ready_i |=> $stable(rd_o) && $stable(rd_wdata_o) &&
      $stable(redirect_o) && $stable(npc_o) && $stable(ebreak_o));

  a_req_xor_valid: assert property (@(posedge clk) disable iff (rst)
    !(mem_req_o && ex_valid_o));

endmodule

`default_nettype wire

// ==== source/exu_top.sv ====
`default_nettype none

module exu_top
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  wire logic            clk,
  input  wire logic            rst,
  // issue
  input  wire logic            issue_valid_i,
  output logic                 issue_ready_o,
  input  wire logic [31:0]     issue_inst_i,
  input  wire logic [XLEN-1:0] issue_pc_i,
  input  wire logic [XLEN-1:0] issue_src1_i,
  input  wire logic [XLEN-1:0] issue_src2_i,
  input  wire logic [XLEN-1:0] issue_base_i,
  input  wire logic [XLEN-1:0] issue_imm_i,
  input  wire alu_op_e         issue_alu_op_i,
  // memory
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic      [XLEN-1:0] mem_addr_o,
  output logic      [XLEN-1:0] mem_wdata_o,
  input  wire logic [XLEN-1:0] mem_rdata_i,
  input  wire logic            mem_rvalid_i,
  input  wire logic            mem_wready_i,
  // writeback
  output logic                 ex_valid_o,
  input  wire logic            ex_ready_i,
  output logic      [4:0]      rd_o,
  output logic      [XLEN-1:0] rd_wdata_o,
  output logic                 redirect_o,
  output logic      [XLEN-1:0] npc_o,
  output logic                 ebreak_o
);

  exu_issue_if #(.XLEN(XLEN)) issue_bus ();

  assign issue_bus.valid  = issue_valid_i;
  assign issue_bus.inst   = issue_inst_i;
  assign issue_bus.pc     = issue_pc_i;
  assign issue_bus.src1   = issue_src1_i;
  assign issue_bus.src2   = issue_src2_i;
  assign issue_bus.base   = issue_base_i;
  assign issue_bus.imm    = issue_imm_i;
  assign issue_bus.alu_op = issue_alu_op_i;
  assign issue_ready_o    = issue_bus.ready;

  exu_core #(.XLEN(XLEN)) i_core (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue_bus),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wready_i (mem_wready_i),
    .ex_valid_o   (ex_valid_o),
    .ex_ready_i   (ex_ready_i),
    .rd_o         (rd_o),
    .rd_wdata_o   (rd_wdata_o),
    .redirect_o   (redirect_o),
    .npc_o        (npc_o),
    .ebreak_o     (ebreak_o)
  );

endmodule

`default_nettype wire

// ==== bench/exu_tb.sv ====
`default_nettype none

module exu_tb
  import exu_pkg::*;
;

  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DELAY     = 10;
  localparam int WATCHDOG_CYCLES = 400 * 20;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        redirect;
    logic [31:0] npc;
    logic        ebreak;
  } result_t;

  logic        clk;
  logic        rst;
  logic        issue_valid_i;
  logic        issue_ready_o;
  logic [31:0] issue_inst_i;
  logic [31:0] issue_pc_i;
  logic [31:0] issue_src1_i;
  logic [31:0] issue_src2_i;
  logic [31:0] issue_base_i;
  logic [31:0] issue_imm_i;
  alu_op_e     issue_alu_op_i;
  logic        mem_req_o;
  logic        mem_we_o;
  logic [31:0] mem_addr_o;
  logic [31:0] mem_wdata_o;
  logic [31:0] mem_rdata_i;
  logic        mem_rvalid_i;
  logic        mem_wready_i;
  logic        ex_valid_o;
  logic        ex_ready_i;
  logic [4:0]  rd_o;
  logic [31:0] rd_wdata_o;
  logic        redirect_o;
  logic [31:0] npc_o;
  logic        ebreak_o;

  // reference model state
  result_t     exp_q[$];
  logic [31:0] model_ram [16];
  logic [31:0] m_mstatus = '0;
  logic [31:0] m_mtvec   = '0;
  logic [31:0] m_mepc    = '0;
  logic [31:0] m_mcause  = '0;

  logic [31:0] ram [16];
  string       test_name = "reset";
  logic        stall_q = 1'b0;
  logic [1:0]  expect_next = 2'd0;
  result_t     prev_out;

  alu_op_e     branch_ops [6] = '{ALU_SUB, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLE, ALU_SLEU};
  logic [11:0] csr_addrs [4]  = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};

  exu_top #(.XLEN(32)) i_dut (
    .clk (clk), .rst (rst),
    .issue_valid_i (issue_valid_i), .issue_ready_o (issue_ready_o),
    .issue_inst_i (issue_inst_i), .issue_pc_i (issue_pc_i),
    .issue_src1_i (issue_src1_i), .issue_src2_i (issue_src2_i),
    .issue_base_i (issue_base_i), .issue_imm_i (issue_imm_i),
    .issue_alu_op_i (issue_alu_op_i),
    .mem_req_o (mem_req_o), .mem_we_o (mem_we_o),
    .mem_addr_o (mem_addr_o), .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i), .mem_rvalid_i (mem_rvalid_i),
    .mem_wready_i (mem_wready_i),
    .ex_valid_o (ex_valid_o), .ex_ready_i (ex_ready_i),
    .rd_o (rd_o), .rd_wdata_o (rd_wdata_o), .redirect_o (redirect_o),
    .npc_o (npc_o), .ebreak_o (ebreak_o)
  );

  task automatic report_fatal(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // hashed so that every word differs
  function automatic logic [31:0] fill_word(input int idx);
    return 32'h9e3779b9 * 32'(idx + 1);
  endfunction

  function automatic logic [31:0] encode(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm12);
    return {imm12, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] model_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << sh;
      ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'b0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return $unsigned($signed(a) >>> sh);
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLE:  return {31'b0, $signed(a) <= $signed(b)};
      ALU_SLEU: return {31'b0, a <= b};
      default:  return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] model_csr_read(input logic [11:0] a);
    case (a)
      CSR_MSTATUS: return m_mstatus;
      CSR_MTVEC:   return m_mtvec;
      CSR_MEPC:    return m_mepc;
      CSR_MCAUSE:  return m_mcause;
      default:     return 32'h0;
    endcase
  endfunction

  task automatic model_csr_write(input logic [11:0] a, input logic [31:0] v);
    case (a)
      CSR_MSTATUS: m_mstatus = v;
      CSR_MTVEC:   m_mtvec = v;
      CSR_MEPC:    m_mepc = v;
      CSR_MCAUSE:  m_mcause = v;
      default:     ;
    endcase
  endtask

  // expected result of the instruction on the issue port right now
  task automatic model_issue();
    result_t     r;
    logic [31:0] w;
    logic [31:0] alu;
    logic [31:0] target;
    logic [31:0] old;
    logic [31:0] opnd;
    logic [31:0] nv;
    logic [2:0]  f3;
    logic [11:0] f12;
    w = issue_inst_i;
    f3 = w[14:12];
    f12 = w[31:20];
    alu = model_alu(issue_alu_op_i, issue_src1_i, issue_src2_i);
    target = issue_base_i + issue_imm_i;
    r.rd = w[11:7];
    r.wdata = alu;
    r.redirect = 1'b0;
    r.npc = target;
    r.ebreak = 1'b0;
    case (w[6:0])
      OPC_BRANCH: begin
        r.rd = 5'd0;
        if (issue_alu_op_i == ALU_SUB) begin
          r.redirect = (alu == 32'h0);
        end else if (issue_alu_op_i inside {ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLE, ALU_SLEU}) begin
          r.redirect = (alu != 32'h0);
        end
      end
      OPC_JAL, OPC_JALR: r.redirect = 1'b1;
      OPC_STORE: begin
        r.rd = 5'd0;
        model_ram[target[5:2]] = issue_src2_i;
      end
      OPC_LOAD: r.wdata = model_ram[target[5:2]];
      OPC_SYSTEM: begin
        old = model_csr_read(f12);
        r.wdata = old;
        opnd = f3[2] ? {27'b0, w[19:15]} : issue_src1_i;
        if (f3 != 3'b000) begin
          case (f3[1:0])
            2'b01:   nv = opnd;
            2'b10:   nv = old | opnd;
            default: nv = old & ~opnd;
          endcase
          model_csr_write(f12, nv);
        end else if (f12 == FUNCT12_ECALL) begin
          r.redirect = 1'b1;
          r.npc = m_mtvec;
          m_mepc = issue_pc_i;
          m_mcause = 32'd11;
        end else if (f12 == FUNCT12_MRET) begin
          r.redirect = 1'b1;
          r.npc = m_mepc;
          m_mstatus[3] = m_mstatus[7];
          m_mstatus[7] = 1'b1;
        end else if (f12 == FUNCT12_EBREAK) begin
          r.ebreak = 1'b1;
        end
      end
      default: ;
    endcase
    if (r.rd == 5'd0) r.wdata = 32'h0;
    exp_q.push_back(r);
  endtask

  task automatic compare_head();
    result_t e;
    assert (exp_q.size() != 0)
      else report_fatal("a result was handed over with no instruction outstanding");
    e = exp_q.pop_front();
    check_value("rd", 32'(e.rd), 32'(rd_o));
    check_value("rd_wdata", e.wdata, rd_wdata_o);
    check_value("redirect", 32'(e.redirect), 32'(redirect_o));
    if (e.redirect) check_value("npc", e.npc, npc_o);
    check_value("ebreak", 32'(e.ebreak), 32'(ebreak_o));
  endtask

  // enters at the drive point and returns at the drive point after the handshake
  task automatic send(input logic [31:0] inst, input logic [31:0] pc, input logic [31:0] src1,
                      input logic [31:0] src2, input logic [31:0] base,
                      input logic [31:0] imm, input alu_op_e op);
    logic got;
    got = 1'b0;
    issue_valid_i = 1'b1;
    issue_inst_i = inst;
    issue_pc_i = pc;
    issue_src1_i = src1;
    issue_src2_i = src2;
    issue_base_i = base;
    issue_imm_i = imm;
    issue_alu_op_i = op;
    while (!got) begin
      @(negedge clk);
      got = issue_ready_o;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    issue_valid_i = 1'b0;
    if ($urandom_range(3, 0) == 0) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic send_csr(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] csr,
                          input logic [31:0] val);
    if (f3[2]) send(encode(OPC_SYSTEM, f3, rd, val[4:0], csr), 32'h400, $urandom, 32'h0,
                    32'h0, 32'h0, ALU_ADD);
    else send(encode(OPC_SYSTEM, f3, rd, 5'd1, csr), 32'h400, val, 32'h0, 32'h0, 32'h0,
              ALU_ADD);
  endtask

  task automatic send_priv(input logic [11:0] f12, input logic [31:0] pc);
    send(encode(OPC_SYSTEM, 3'b000, 5'd0, 5'd0, f12), pc, 32'h0, 32'h0, 32'h0, 32'h0, ALU_ADD);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_fatal("watchdog expired before all instructions completed");
  end

  initial begin : ready_driver
    ex_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      ex_ready_i = ($urandom_range(3, 0) != 0);
    end
  end

  // answers each request after 0 to 5 idle cycles
  initial begin : mem_responder
    logic [31:0] addr_held;
    logic [31:0] wdata_held;
    logic        we_held;
    int unsigned idle;
    mem_rvalid_i = 1'b0;
    mem_wready_i = 1'b0;
    mem_rdata_i = '0;
    for (int k = 0; k < 16; k++) ram[k] = fill_word(k);
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      mem_rvalid_i = 1'b0;
      mem_wready_i = 1'b0;
      mem_rdata_i = $urandom;
      if (mem_req_o) begin
        addr_held = mem_addr_o;
        wdata_held = mem_wdata_o;
        we_held = mem_we_o;
        idle = $urandom_range(5, 0);
        repeat (idle) begin
          @(posedge clk);
          #DRIVE_DELAY;
          check_value("mem_req_hold", 32'h1, 32'(mem_req_o));
          check_value("mem_addr_hold", addr_held, mem_addr_o);
          check_value("mem_wdata_hold", wdata_held, mem_wdata_o);
          check_value("mem_we_hold", 32'(we_held), 32'(mem_we_o));
        end
        if (we_held) begin
          ram[addr_held[5:2]] = wdata_held;
          mem_wready_i = 1'b1;
        end else begin
          mem_rdata_i = ram[addr_held[5:2]];
          mem_rvalid_i = 1'b1;
        end
      end else if ($urandom_range(7, 0) == 0) begin
        // stray pulse while idle
        mem_rvalid_i = 1'b1;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (expect_next == 2'd1) check_value("valid_one_cycle", 32'h1, 32'(ex_valid_o));
      if (expect_next == 2'd2) check_value("mem_req_one_cycle", 32'h1, 32'(mem_req_o));
      expect_next = 2'd0;
      if (stall_q) begin
        check_value("hold_valid", 32'h1, 32'(ex_valid_o));
        check_value("hold_rd", 32'(prev_out.rd), 32'(rd_o));
        check_value("hold_wdata", prev_out.wdata, rd_wdata_o);
        check_value("hold_redirect", 32'(prev_out.redirect), 32'(redirect_o));
        check_value("hold_npc", prev_out.npc, npc_o);
        check_value("hold_ebreak", 32'(prev_out.ebreak), 32'(ebreak_o));
      end
      if (ex_valid_o && ex_ready_i) compare_head();
      if (issue_valid_i && issue_ready_o) begin
        model_issue();
        expect_next = (issue_inst_i[6:0] inside {OPC_LOAD, OPC_STORE}) ? 2'd2 : 2'd1;
      end
      stall_q = ex_valid_o && !ex_ready_i;
      prev_out = '{rd_o, rd_wdata_o, redirect_o, npc_o, ebreak_o};
    end
  end

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [2:0]  f3;
    int unsigned r;
    void'($urandom(12562));
    rst = 1'b1;
    issue_valid_i = 1'b0;
    issue_inst_i = '0;
    issue_pc_i = '0;
    issue_src1_i = '0;
    issue_src2_i = '0;
    issue_base_i = '0;
    issue_imm_i = '0;
    issue_alu_op_i = ALU_ADD;
    for (int k = 0; k < 16; k++) model_ram[k] = fill_word(k);
    repeat (10) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    @(negedge clk);
    check_value("ex_valid", 32'h0, 32'(ex_valid_o));
    check_value("mem_req", 32'h0, 32'(mem_req_o));
    check_value("redirect", 32'h0, 32'(redirect_o));
    check_value("issue_ready", 32'h1, 32'(issue_ready_o));
    @(posedge clk);
    #DRIVE_DELAY;

    test_name = "alu";
    for (int i = 0; i < 150; i++) begin
      rd = (i % 8 == 0) ? 5'd0 : 5'($urandom_range(31, 1));
      send(encode((i % 2 == 0) ? OPC_OP : OPC_OP_IMM, 3'b000, rd, 5'd1, 12'h0), 32'h0,
           $urandom, $urandom, 32'h0, 32'h0, alu_op_e'($urandom_range(11, 0)));
    end

    test_name = "branch_jump";
    for (int i = 0; i < 80; i++) begin
      r = $urandom_range(3, 0);
      a = $urandom;
      b = ($urandom_range(1, 0) == 0) ? a : $urandom;
      pc = 32'($urandom_range(4095, 0)) << 2;
      rd = 5'($urandom_range(31, 0));
      if (r == 0) send(encode(OPC_JAL, 3'b000, rd, 5'd0, 12'h0), pc, pc, 32'd4, pc,
                       32'($urandom_range(255, 0)) << 2, ALU_ADD);
      else if (r == 1) send(encode(OPC_JALR, 3'b000, rd, 5'd2, 12'h0), pc, pc, 32'd4,
                            $urandom, 32'($urandom_range(255, 0)) << 2, ALU_ADD);
      else send(encode(OPC_BRANCH, 3'b000, rd, 5'd3, 12'h0), pc, a, b, pc,
                32'($urandom_range(255, 0)) << 2, branch_ops[$urandom_range(5, 0)]);
    end

    test_name = "store_load";
    for (int i = 0; i < 16; i++) begin
      send(encode(OPC_STORE, 3'b010, 5'($urandom_range(31, 0)), 5'd1, 12'h0), 32'h0,
           $urandom, $urandom, 32'(4 * i), 32'h0, ALU_ADD);
    end
    for (int i = 0; i < 16; i++) begin
      send(encode(OPC_LOAD, 3'b010, 5'($urandom_range(31, 1)), 5'd1, 12'h0), 32'h0,
           $urandom, $urandom, 32'h0, 32'(4 * i), ALU_ADD);
    end
    for (int i = 0; i < 40; i++) begin
      send(encode(($urandom_range(1, 0) == 0) ? OPC_STORE : OPC_LOAD, 3'b010,
                  5'($urandom_range(31, 0)), 5'd1, 12'h0), 32'h0, $urandom, $urandom,
           32'($urandom_range(7, 0)) << 2, 32'($urandom_range(7, 0)) << 2, ALU_ADD);
    end

    test_name = "csr_trap";
    send_csr(F3_CSRRW, 5'd1, CSR_MTVEC, 32'h100);
    send_csr(F3_CSRRW, 5'd2, CSR_MTVEC, 32'h180);
    send_csr(F3_CSRRS, 5'd3, CSR_MSTATUS, 32'h80);
    send_csr(F3_CSRRC, 5'd4, CSR_MSTATUS, 32'h08);
    send_csr(F3_CSRRSI, 5'd5, CSR_MCAUSE, 32'd5);
    send_csr(F3_CSRRCI, 5'd6, CSR_MCAUSE, 32'd1);
    send_csr(F3_CSRRWI, 5'd7, CSR_MEPC, 32'd31);
    send_priv(FUNCT12_ECALL, 32'h240);
    send_csr(F3_CSRRS, 5'd8, CSR_MEPC, 32'h0);
    send_csr(F3_CSRRS, 5'd9, CSR_MCAUSE, 32'h0);
    send_priv(FUNCT12_MRET, 32'h300);
    send_csr(F3_CSRRS, 5'd10, CSR_MSTATUS, 32'h0);
    send_priv(FUNCT12_EBREAK, 32'h304);

    test_name = "csr_random";
    for (int i = 0; i < 40; i++) begin
      r = $urandom_range(5, 0);
      f3 = (r < 3) ? 3'(r + 1) : 3'(r + 2);
      if (i % 10 == 9) send_priv(($urandom_range(1, 0) == 0) ? FUNCT12_ECALL : FUNCT12_MRET,
                                 32'($urandom_range(4095, 0)) << 2);
      else send_csr(f3, 5'($urandom_range(31, 0)), csr_addrs[$urandom_range(3, 0)], $urandom);
    end

    test_name = "drain";
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    if (!ex_valid_o) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("a result was handed over after the last instruction had completed");
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/exu_pkg.sv
source/exu_issue_if.sv
source/exu_csr_if.sv
source/exu_alu.sv
source/exu_csr.sv
source/exu_redirect.sv
source/exu_core.sv
source/exu_top.sv
bench/exu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module exu_tb \
  -f list.f -o exu_tb_sim \
  && ./obj_dir/exu_tb_sim \
  || { echo "simulation exited with an error"; exit 1; }
